//--- logic/soc_cfg_pkg.sv
// system sizes and counts shared across the fabric
// bus widths, master and slave population, port widths
package soc_cfg_pkg;

    // bus word sizes
    localparam int data_width = 16;
    localparam int addr_width = 16;

    // bus population
    localparam int num_masters = 2;
    localparam int num_slaves  = 4;

    // index width for a master number, never below one bit
    localparam int master_bits = (num_masters > 1) ? $clog2(num_masters) : 1;

    // gpio port widths
    localparam int gpio0_pins = 8;
    localparam int gpio1_pins = 16;

    // power-on reset stretch
    localparam int reset_hold_cycles = 8;

    // counter width able to hold reset_hold_cycles
    localparam int hold_bits = $clog2(reset_hold_cycles + 1);

endpackage

//--- logic/apb_map_pkg.sv
// APB address map, slave indices and register cells
// address word union seen by the interconnect and the slaves
package apb_map_pkg;

    // address split, top nibble picks the slave
    localparam int slave_bits  = 4;
    localparam int offset_bits = 12;

    // slave indices on the shared bus
    localparam int sel_gpio0 = 0;
    localparam int sel_gpio1 = 1;
    localparam int sel_regs  = 2;
    localparam int sel_bram  = 3;

    // system register block
    localparam int regs_cells      = 8;
    localparam int regs_idx_bits   = $clog2(regs_cells);
    localparam int reg_num_masters = 0;
    localparam int reg_num_slaves  = 1;

    // block ram depth
    localparam int bram_cells    = 64;
    localparam int bram_idx_bits = $clog2(bram_cells);

    typedef union packed {
        logic [slave_bits+offset_bits-1:0] raw;
        struct packed {
            logic [slave_bits-1:0]  slave;
            logic [offset_bits-1:0] offset;
        } field;
    } apb_addr_u;

endpackage

//--- logic/reset_hold.sv
// power-on reset stretcher
`timescale 1ns/1ps

module reset_hold (
    input  logic clk,
    input  logic reset,
    output logic soft_reset
);
    import soc_cfg_pkg::*;

    logic [hold_bits-1:0] hold_cnt;

    // reload while reset is high, count down once released
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt <= hold_bits'(reset_hold_cycles);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // fabric stays in reset until the count runs out
    assign soft_reset = (hold_cnt != '0);

endmodule

//--- logic/apb_intercon.sv
// shared APB interconnect, round-robin master arbitration
// slave decode from the top address bits and response return
`timescale 1ns/1ps

module apb_intercon (
    input  logic clk,
    input  logic reset,
    // master side, one slice per master
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::addr_width-1:0] m_paddr,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_pwrite,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_psel,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_penable,
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] m_pwdata,
    output logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] m_prdata,
    output logic [soc_cfg_pkg::num_masters-1:0]                         m_pready,
    // shared slave side
    output logic [soc_cfg_pkg::addr_width-1:0]                          s_paddr,
    output logic                                                        s_pwrite,
    output logic                                                        s_penable,
    output logic [soc_cfg_pkg::data_width-1:0]                          s_pwdata,
    output logic [soc_cfg_pkg::num_slaves-1:0]                          s_psel,
    input  logic [soc_cfg_pkg::num_slaves*soc_cfg_pkg::data_width-1:0]  s_prdata,
    input  logic [soc_cfg_pkg::num_slaves-1:0]                          s_pready
);
    import soc_cfg_pkg::*;
    import apb_map_pkg::*;

    logic [master_bits-1:0] grant;
    logic [master_bits-1:0] next_grant;
    logic                   any_req;
    logic                   setup_q;
    logic                   access_q;
    logic                   done_q;
    logic                   idle;
    apb_addr_u              addr;
    logic                   sel_ready;
    logic [data_width-1:0]  sel_rdata;
    logic                   xfer_done;

    //////////////////////////////
    // arbitration
    //////////////////////////////

    assign idle = !(setup_q || access_q || done_q);

    // search from the master after the last grant, nearest one wins
    always_comb begin
        int idx;
        next_grant = grant;
        any_req    = 1'b0;
        for (int k = num_masters; k >= 1; k--) begin
            idx = (int'(grant) + k) % num_masters;
            if (m_psel[idx]) begin
                next_grant = master_bits'(idx);
                any_req    = 1'b1;
            end
        end
    end

    // phases: setup, access, then one done cycle before the next grant
    always_ff @(posedge clk) begin
        if (reset) begin
            grant    <= master_bits'(num_masters - 1);
            setup_q  <= 1'b0;
            access_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= xfer_done;
            if (idle && any_req) begin
                grant   <= next_grant;
                setup_q <= 1'b1;
            end else if (setup_q) begin
                setup_q  <= 1'b0;
                access_q <= 1'b1;
            end else if (xfer_done) begin
                access_q <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // shared bus and decode
    //////////////////////////////

    assign s_paddr   = m_paddr[grant*addr_width +: addr_width];
    assign s_pwrite  = m_pwrite[grant];
    assign s_pwdata  = m_pwdata[grant*data_width +: data_width];
    assign s_penable = access_q;
    assign addr.raw  = s_paddr;

    always_comb begin
        s_psel = '0;
        for (int i = 0; i < num_slaves; i++)
            s_psel[i] = (setup_q || access_q) && (int'(addr.field.slave) == i);
    end

    // no slave selected means unmapped, done at once with zero data
    always_comb begin
        sel_ready = 1'b1;
        sel_rdata = '0;
        for (int i = 0; i < num_slaves; i++) begin
            if (s_psel[i]) begin
                sel_ready = s_pready[i];
                sel_rdata = s_prdata[i*data_width +: data_width];
            end
        end
    end

    assign xfer_done = access_q && m_penable[grant] && sel_ready;

    // response goes to the granted master only
    always_comb begin
        m_pready = '0;
        m_prdata = '0;
        if (xfer_done) begin
            m_pready[grant]                          = 1'b1;
            m_prdata[grant*data_width +: data_width] = sel_rdata;
        end
    end

endmodule

//--- logic/gpio_apb.sv
// APB output port, one register driving the pins
`timescale 1ns/1ps

module gpio_apb #(
    parameter int pins = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [soc_cfg_pkg::data_width-1:0]  pwdata,
    output logic [soc_cfg_pkg::data_width-1:0]  prdata,
    output logic                                pready,
    output logic [pins-1:0]                     gpio
);
    import soc_cfg_pkg::*;

    logic [pins-1:0] pins_q;

    // answers in the first access cycle
    assign pready = psel && penable;

    // any offset hits the same register
    always_ff @(posedge clk) begin
        if (reset) begin
            pins_q <= '0;
        end else if (pready && pwrite) begin
            pins_q <= pwdata[pins-1:0];
        end
    end

    assign gpio = pins_q;

    // read back zero-extended
    assign prdata = data_width'(pins_q);

endmodule

//--- logic/sys_regs_apb.sv
// APB system register block
// two read-only info cells, the rest scratch
`timescale 1ns/1ps

module sys_regs_apb (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [soc_cfg_pkg::addr_width-1:0]  paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [soc_cfg_pkg::data_width-1:0]  pwdata,
    output logic [soc_cfg_pkg::data_width-1:0]  prdata,
    output logic                                pready
);
    import soc_cfg_pkg::*;
    import apb_map_pkg::*;

    logic [data_width-1:0]    cells [regs_cells];
    logic [regs_idx_bits-1:0] idx;
    logic                     access;
    logic                     read_only;

    // cell index wraps at regs_cells
    assign idx    = paddr[regs_idx_bits-1:0];
    assign access = psel && penable;

    assign read_only = (int'(idx) == reg_num_masters) || (int'(idx) == reg_num_slaves);

    // info cells load their counts on reset and ignore writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regs_cells; i++)
                cells[i] <= '0;
            cells[reg_num_masters] <= data_width'(num_masters);
            cells[reg_num_slaves]  <= data_width'(num_slaves);
        end else if (access && pwrite && !read_only) begin
            cells[idx] <= pwdata;
        end
    end

    assign pready = access;
    assign prdata = cells[idx];

endmodule

//--- logic/bram_apb.sv
// APB block RAM slave with one wait state
`timescale 1ns/1ps

module bram_apb (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [soc_cfg_pkg::addr_width-1:0]  paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [soc_cfg_pkg::data_width-1:0]  pwdata,
    output logic [soc_cfg_pkg::data_width-1:0]  prdata,
    output logic                                pready
);
    import soc_cfg_pkg::*;
    import apb_map_pkg::*;

    logic [data_width-1:0]    mem [bram_cells];
    logic [data_width-1:0]    rdata_q;
    logic [bram_idx_bits-1:0] idx;
    logic                     wait_q;
    logic                     first;

    assign idx = paddr[bram_idx_bits-1:0];

    // first access cycle does the ram access
    assign first = psel && penable && !wait_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= first;
        end
    end

    // one port, read data registered
    always_ff @(posedge clk) begin
        if (first) begin
            if (pwrite) begin
                mem[idx] <= pwdata;
            end
            rdata_q <= mem[idx];
        end
    end

    // done in the second access cycle
    assign pready = psel && penable && wait_q;
    assign prdata = rdata_q;

endmodule

//--- logic/periph_soc.sv
// peripheral fabric top, reset stretcher, interconnect and slaves
// masters come in on the packed m_* ports
`timescale 1ns/1ps

module periph_soc (
    input  logic clk,
    input  logic reset,
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::addr_width-1:0] m_paddr,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_pwrite,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_psel,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_penable,
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] m_pwdata,
    output logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] m_prdata,
    output logic [soc_cfg_pkg::num_masters-1:0]                         m_pready,
    output logic [soc_cfg_pkg::gpio0_pins-1:0]                          gpio0,
    output logic [soc_cfg_pkg::gpio1_pins-1:0]                          gpio1
);
    import soc_cfg_pkg::*;
    import apb_map_pkg::*;

    logic                             soft_reset;
    logic [addr_width-1:0]            s_paddr;
    logic                             s_pwrite;
    logic                             s_penable;
    logic [data_width-1:0]            s_pwdata;
    logic [num_slaves-1:0]            s_psel;
    logic [num_slaves*data_width-1:0] s_prdata;
    logic [num_slaves-1:0]            s_pready;

    //////////////////////////////
    // reset and bus
    //////////////////////////////

    reset_hold u_reset_hold (
        .clk        (clk),
        .reset      (reset),
        .soft_reset (soft_reset)
    );

    apb_intercon u_intercon (
        .clk       (clk),
        .reset     (soft_reset),
        .m_paddr   (m_paddr),
        .m_pwrite  (m_pwrite),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready),
        .s_paddr   (s_paddr),
        .s_pwrite  (s_pwrite),
        .s_penable (s_penable),
        .s_pwdata  (s_pwdata),
        .s_psel    (s_psel),
        .s_prdata  (s_prdata),
        .s_pready  (s_pready)
    );

    //////////////////////////////
    // slaves
    //////////////////////////////

    gpio_apb #(
        .pins (gpio0_pins)
    ) u_gpio0 (
        .clk     (clk),
        .reset   (soft_reset),
        .psel    (s_psel[sel_gpio0]),
        .penable (s_penable),
        .pwrite  (s_pwrite),
        .pwdata  (s_pwdata),
        .prdata  (s_prdata[sel_gpio0*data_width +: data_width]),
        .pready  (s_pready[sel_gpio0]),
        .gpio    (gpio0)
    );

    // wider port, same block
    gpio_apb #(
        .pins (gpio1_pins)
    ) u_gpio1 (
        .clk     (clk),
        .reset   (soft_reset),
        .psel    (s_psel[sel_gpio1]),
        .penable (s_penable),
        .pwrite  (s_pwrite),
        .pwdata  (s_pwdata),
        .prdata  (s_prdata[sel_gpio1*data_width +: data_width]),
        .pready  (s_pready[sel_gpio1]),
        .gpio    (gpio1)
    );

    sys_regs_apb u_regs (
        .clk     (clk),
        .reset   (soft_reset),
        .paddr   (s_paddr),
        .psel    (s_psel[sel_regs]),
        .penable (s_penable),
        .pwrite  (s_pwrite),
        .pwdata  (s_pwdata),
        .prdata  (s_prdata[sel_regs*data_width +: data_width]),
        .pready  (s_pready[sel_regs])
    );

    bram_apb u_bram (
        .clk     (clk),
        .reset   (soft_reset),
        .paddr   (s_paddr),
        .psel    (s_psel[sel_bram]),
        .penable (s_penable),
        .pwrite  (s_pwrite),
        .pwdata  (s_pwdata),
        .prdata  (s_prdata[sel_bram*data_width +: data_width]),
        .pready  (s_pready[sel_bram])
    );

endmodule

//--- tests/intercon_props.sv
// concurrent checks on the interconnect grant and shared bus handshake
`timescale 1ns/1ps

module intercon_props (
    input logic                                                        clk,
    input logic                                                        reset,
    input logic [soc_cfg_pkg::num_masters-1:0]                         m_pready,
    input logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] m_prdata,
    input logic [soc_cfg_pkg::num_slaves-1:0]                          s_psel,
    input logic                                                        s_penable
);

    // failed assertions so far
    int assert_errors = 0;

    // one response at a time
    pready_onehot: assert property (@(posedge clk) disable iff (reset !== 1'b0)
        $onehot0(m_pready))
        else begin
            $error("more than one master sees pready");
            assert_errors++;
        end

    psel_onehot: assert property (@(posedge clk) disable iff (reset !== 1'b0)
        $onehot0(s_psel))
        else begin
            $error("more than one slave selected");
            assert_errors++;
        end

    // setup cycle first, then penable with the select held
    setup_before_enable: assert property (@(posedge clk) disable iff (reset !== 1'b0)
        $rose(|s_psel) |-> !s_penable)
        else begin
            $error("penable high in the setup cycle");
            assert_errors++;
        end

    enable_holds_select: assert property (@(posedge clk) disable iff (reset !== 1'b0)
        s_penable |-> $stable(s_psel))
        else begin
            $error("select changed while penable was high");
            assert_errors++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset === 1'b1 |-> (m_pready == '0) && (m_prdata == '0))
        else begin
            $error("master outputs active during reset");
            assert_errors++;
        end

endmodule

bind apb_intercon intercon_props u_props (
    .clk       (clk),
    .reset     (reset),
    .m_pready  (m_pready),
    .m_prdata  (m_prdata),
    .s_psel    (s_psel),
    .s_penable (s_penable)
);

//--- tests/soc_checker.sv
// checker on the fabric master ports and the gpio pins
`timescale 1ns/1ps

module soc_checker (
    input  logic                                                        clk,
    input  logic                                                        reset,
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::addr_width-1:0] m_paddr,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_pwrite,
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] m_pwdata,
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] m_prdata,
    input  logic [soc_cfg_pkg::num_masters-1:0]                         m_pready,
    input  logic [soc_cfg_pkg::num_masters*soc_cfg_pkg::data_width-1:0] exp_rdata,
    input  logic [soc_cfg_pkg::gpio0_pins-1:0]                          gpio0,
    input  logic [soc_cfg_pkg::gpio1_pins-1:0]                          gpio1,
    output int                                                          read_errors,
    output int                                                          pin_errors,
    output int                                                          reads_seen
);
    import soc_cfg_pkg::*;
    import apb_map_pkg::*;

    logic [gpio0_pins-1:0] gpio0_exp;
    logic [gpio1_pins-1:0] gpio1_exp;

    always @(posedge clk) begin
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] rdata;
        logic [data_width-1:0] wdata;
        int                    slave;
        if (reset) begin
            gpio0_exp <= '0;
            gpio1_exp <= '0;
        end else begin
            // pins follow the last completed write
            if (gpio0 !== gpio0_exp) begin
                $display("Fail at %0t: gpio0 is %h, expected %h", $time, gpio0, gpio0_exp);
                pin_errors++;
            end
            if (gpio1 !== gpio1_exp) begin
                $display("Fail at %0t: gpio1 is %h, expected %h", $time, gpio1, gpio1_exp);
                pin_errors++;
            end
            for (int m = 0; m < num_masters; m++) begin
                if (m_pready[m]) begin
                    addr  = m_paddr[m*addr_width +: addr_width];
                    rdata = m_prdata[m*data_width +: data_width];
                    wdata = m_pwdata[m*data_width +: data_width];
                    slave = int'(addr[addr_width-1 -: slave_bits]);
                    if (!m_pwrite[m]) begin
                        reads_seen++;
                        if (rdata !== exp_rdata[m*data_width +: data_width]) begin
                            $display("Fail at %0t: master %0d read %h from %h, expected %h",
                                     $time, m, rdata, addr,
                                     exp_rdata[m*data_width +: data_width]);
                            read_errors++;
                        end
                    end else if (slave == sel_gpio0) begin
                        gpio0_exp <= wdata[gpio0_pins-1:0];
                    end else if (slave == sel_gpio1) begin
                        gpio1_exp <= wdata[gpio1_pins-1:0];
                    end
                end
            end
        end
    end

endmodule

//--- tests/periph_soc_tb.sv
// testbench for the peripheral fabric
// clock, reset, vector reader, per-master APB drivers, watchdog and report
`timescale 1ns/1ps

module periph_soc_tb;
    import soc_cfg_pkg::*;

    localparam int half_period  = 4;
    localparam int reset_cycles = 16;
    localparam int vec_fields   = 5;
    localparam int max_vectors  = 64;

    logic                              clk;
    logic                              reset;
    logic [num_masters*addr_width-1:0] m_paddr;
    logic [num_masters-1:0]            m_pwrite;
    logic [num_masters-1:0]            m_psel;
    logic [num_masters-1:0]            m_penable;
    logic [num_masters*data_width-1:0] m_pwdata;
    logic [num_masters*data_width-1:0] m_prdata;
    logic [num_masters-1:0]            m_pready;
    logic [num_masters*data_width-1:0] exp_rdata;
    logic [gpio0_pins-1:0]             gpio0;
    logic [gpio1_pins-1:0]             gpio1;
    logic [data_width-1:0]             vec_mem [vec_fields*max_vectors];
    logic                              loaded;
    int                                num_vectors;
    int                                num_reads;
    int                                other_errors;
    int                                read_errors;
    int                                pin_errors;
    int                                assert_errors;
    int                                reads_seen;

    periph_soc uut (
        .clk       (clk),
        .reset     (reset),
        .m_paddr   (m_paddr),
        .m_pwrite  (m_pwrite),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready),
        .gpio0     (gpio0),
        .gpio1     (gpio1)
    );

    soc_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .m_paddr     (m_paddr),
        .m_pwrite    (m_pwrite),
        .m_pwdata    (m_pwdata),
        .m_prdata    (m_prdata),
        .m_pready    (m_pready),
        .exp_rdata   (exp_rdata),
        .gpio0       (gpio0),
        .gpio1       (gpio1),
        .read_errors (read_errors),
        .pin_errors  (pin_errors),
        .reads_seen  (reads_seen)
    );

    always #half_period clk = ~clk;

    //////////////////////////////
    // APB master drivers
    //////////////////////////////

    // one transfer, entered just after a falling edge
    task automatic run_transfer(input int m, input logic wr,
                                input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] wdata,
                                input logic [data_width-1:0] exp_data);
        m_paddr[m*addr_width +: addr_width]   = addr;
        m_pwdata[m*data_width +: data_width]  = wdata;
        exp_rdata[m*data_width +: data_width] = exp_data;
        m_pwrite[m]  = wr;
        m_psel[m]    = 1'b1;
        m_penable[m] = 1'b0;
        @(negedge clk);
        m_penable[m] = 1'b1;
        // hold until granted and the slave answers
        do
            @(negedge clk);
        while (!m_pready[m]);
        // transfer ends on the rising edge in between
        @(negedge clk);
        m_psel[m]    = 1'b0;
        m_penable[m] = 1'b0;
    endtask

    task automatic drive_master(input int m);
        int base;
        for (int i = 0; i < num_vectors; i++) begin
            base = i * vec_fields;
            if (int'(vec_mem[base]) == m)
                run_transfer(m, vec_mem[base+1][0], vec_mem[base+2], vec_mem[base+3],
                             vec_mem[base+4]);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        m_paddr       = '0;
        m_pwrite      = '0;
        m_psel        = '0;
        m_penable     = '0;
        m_pwdata      = '0;
        exp_rdata     = '0;
        loaded        = 1'b0;
        num_vectors   = 0;
        num_reads     = 0;
        other_errors  = 0;
        assert_errors = 0;

        $readmemh("tests/soc_vectors.txt", vec_mem);
        // list ends at a line whose master field is ff
        while (num_vectors < max_vectors && vec_mem[num_vectors*vec_fields] !== 16'h00ff) begin
            if (vec_mem[num_vectors*vec_fields+1][0] == 1'b0)
                num_reads++;
            num_vectors++;
        end
        if (num_vectors == max_vectors || num_vectors == 0) begin
            $display("The vector file is missing, empty or has no end marker");
            other_errors++;
            num_vectors = 0;
        end
        loaded = 1'b1;

        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        // fabric stays in soft reset a little longer
        repeat (reset_hold_cycles + 1) @(negedge clk);

        fork
            drive_master(0);
            drive_master(1);
        join
        repeat (4) @(negedge clk);

        if (reads_seen != num_reads) begin
            $display("Only %0d of %0d reads completed", reads_seen, num_reads);
            other_errors++;
        end
        // failed interconnect assertions
        assert_errors = uut.u_intercon.u_props.assert_errors;
        $display("Read mismatches %0d, pin mismatches %0d, assertion failures %0d, other %0d",
                 read_errors, pin_errors, assert_errors, other_errors);
        if (read_errors + pin_errors + assert_errors + other_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        int limit;
        wait (loaded);
        limit = num_vectors * 20 + reset_cycles + reset_hold_cycles;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- tests/soc_vectors.txt
// master write address wdata expected_rdata, one transfer per line (hex)
// expected_rdata is checked on reads only, a line with master ff ends the list
0 0 2000 0000 0002
0 0 2001 0000 0004
0 1 2000 ffff 0000
0 0 2000 0000 0002
0 1 2002 a5c3 0000
0 0 2002 0000 a5c3
0 1 3010 1111 0000
0 1 3011 2222 0000
0 0 3010 0000 1111
0 0 3011 0000 2222
0 1 0000 abcd 0000
0 0 0004 0000 00cd
0 0 5000 0000 0000
1 1 2001 1234 0000
1 0 2001 0000 0004
1 1 3020 3333 0000
1 1 3021 4444 0000
1 0 3020 0000 3333
1 0 3021 0000 4444
1 0 2002 0000 a5c3
1 1 1000 beef 0000
1 0 1000 0000 beef
1 0 f123 0000 0000
ff 0 0000 0000 0000

//--- files.f
logic/soc_cfg_pkg.sv
logic/apb_map_pkg.sv
logic/reset_hold.sv
logic/apb_intercon.sv
logic/gpio_apb.sv
logic/sys_regs_apb.sv
logic/bram_apb.sv
logic/periph_soc.sv
tests/intercon_props.sv
tests/soc_checker.sv
tests/periph_soc_tb.sv

//--- Bender.yml
package:
  name: periph_soc

sources:
  - files:
      - logic/soc_cfg_pkg.sv
      - logic/apb_map_pkg.sv
      - logic/reset_hold.sv
      - logic/apb_intercon.sv
      - logic/gpio_apb.sv
      - logic/sys_regs_apb.sv
      - logic/bram_apb.sv
      - logic/periph_soc.sv
  - target: test
    files:
      - tests/intercon_props.sv
      - tests/soc_checker.sv
      - tests/periph_soc_tb.sv
